// ==== id_serialize.f ====
logic/id_serialize_pkg.sv
logic/ar_demux.sv
logic/id_serializer.sv
logic/ar_arbiter.sv
logic/id_serialize.sv
bench/id_serialize_asserts.sv
bench/id_serialize_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the read ID serializer testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f id_serialize.f \
  --top-module id_serialize_tb -o id_serialize_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/id_serialize_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Everything OK" "$log"; then
  echo "Result: pass"
  exit 0
else
  echo "Result: fail"
  exit 1
fi

// ==== bench/id_serialize_tb.sv ====
// Read ID serializer testbench with clock, reset and random AR stimulus,
// memory slave model on the master port and per-ID scoreboard on the slave port
`timescale 1ns/1ps

module id_serialize_tb import id_serialize_pkg::*; ();

  localparam int unsigned NumTxns       = 300;
  localparam int unsigned NumSlvIds     = 2 ** SlvIdWidth;
  localparam int unsigned TimeoutCycles = 20000;

  logic    clk_i;
  logic    rst_n_i;
  slv_ar_t slv_ar_i;
  logic    ar_valid_i;
  logic    ar_ready_o;
  slv_r_t  slv_r_o;
  logic    r_valid_o;
  logic    r_ready_i;
  mst_ar_t mst_ar_o;
  logic    mst_ar_valid_o;
  logic    mst_ar_ready_i;
  mst_r_t  mst_r_i;
  logic    mst_r_valid_i;
  logic    mst_r_ready_o;

  integer      seed = 32'hacc3;
  // Expected bursts per slave ID in issue order
  slv_ar_t     exp_q[NumSlvIds][$];
  len_t        rx_idx[NumSlvIds] = '{default: '0};
  // Slave ARs accepted but not yet seen on the master port
  slv_ar_t     slot_q[NumSlots][$];
  // Master ARs the memory model still has to answer, tagged with their slave ID
  slv_ar_t     rsp_q[$];
  len_t        beat_k = '0;
  int unsigned mst_cnt[NumSlots] = '{default: 0};
  slv_id_t     mst_owner[NumSlots] = '{default: '0};
  int unsigned issued = 0;
  int unsigned done_cnt = 0;
  int unsigned cycles = 0;
  logic        ar_hs = 1'b0;
  logic        mst_r_hs = 1'b0;

  id_serialize id_serialize_inst (.*);

  bind id_serialize id_serialize_asserts id_serialize_asserts_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function automatic int unsigned rand_below(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_id(input string name, input slv_id_t got, input slv_id_t exp);
    if (got !== exp) begin
      stop_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_mst_id(input string name, input mst_id_t got, input mst_id_t exp);
    if (got !== exp) begin
      stop_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      stop_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_resp(input string name, input resp_t got, input resp_t exp);
    if (got !== exp) begin
      stop_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_last(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  // Slave R beat against the burst being answered and the per-ID issue order
  task automatic check_r_beat();
    slv_id_t s;
    s = slv_r_o.id;
    if (rsp_q.size() == 0) begin
      stop_run("Slave R beat seen while no burst is being answered");
    end
    check_id("slv_r_o.id", s, rsp_q[0].id);
    check_data("slv_r_o.beat.data", slv_r_o.beat.data, exp_q[s][0].addr + addr_t'(rx_idx[s]));
    check_resp("slv_r_o.beat.resp", slv_r_o.beat.resp, resp_t'(0));
    check_last("slv_r_o.beat.last", slv_r_o.beat.last, rx_idx[s] == exp_q[s][0].len);
    if (slv_r_o.beat.last) begin
      void'(exp_q[s].pop_front());
      rx_idx[s] = '0;
      done_cnt++;
    end else begin
      rx_idx[s]++;
    end
  endtask

  // Master AR must be the oldest pending AR of some slot
  task automatic check_mst_ar();
    mst_id_t m;
    mst_id_t hit;
    logic    found;
    slv_ar_t p;
    m     = mst_ar_o.id;
    hit   = '0;
    found = 1'b0;
    for (int i = 0; i < NumSlots; i++) begin
      if (!found && slot_q[mst_id_t'(i)].size() > 0 &&
          slot_q[mst_id_t'(i)][0].addr == mst_ar_o.addr &&
          slot_q[mst_id_t'(i)][0].len == mst_ar_o.len) begin
        hit   = mst_id_t'(i);
        found = 1'b1;
      end
    end
    if (!found) begin
      stop_run("Master AR does not match any pending slave AR");
    end
    p = slot_q[hit].pop_front();
    check_mst_id("mst_ar_o.id", m, p.id[MstIdWidth-1:0]);
    if (mst_cnt[m] != 0 && mst_owner[m] != p.id) begin
      stop_run($sformatf("Master ID %0d carries slave IDs %0d and %0d at once",
                         m, mst_owner[m], p.id));
    end
    mst_owner[m] = p.id;
    mst_cnt[m]++;
    if (mst_cnt[m] > MaxTxnsPerId) begin
      stop_run($sformatf("Master ID %0d has %0d bursts outstanding", m, mst_cnt[m]));
    end
    rsp_q.push_back(p);
  endtask

  // Handshakes are sampled mid-cycle, where every input and output is settled
  always @(negedge clk_i) begin
    ar_hs    = rst_n_i && ar_valid_i && ar_ready_o;
    mst_r_hs = rst_n_i && mst_r_valid_i && mst_r_ready_o;
    if (rst_n_i && r_valid_o && r_ready_i) begin
      check_r_beat();
    end
    if (mst_r_hs) begin
      if (mst_r_i.beat.last) begin
        void'(rsp_q.pop_front());
        mst_cnt[mst_r_i.id]--;
        beat_k = '0;
      end else begin
        beat_k++;
      end
    end
    if (rst_n_i && mst_ar_valid_o && mst_ar_ready_i) begin
      check_mst_ar();
    end
    if (ar_hs) begin
      exp_q[slv_ar_i.id].push_back(slv_ar_i);
      slot_q[slv_ar_i.id[MstIdWidth-1:0]].push_back(slv_ar_i);
    end
  end

  task automatic drive_slave_ar();
    if (ar_valid_i && ar_hs) begin
      ar_valid_i = 1'b0;
    end
    if (!ar_valid_i && issued < NumTxns && rand_below(4) != 0) begin
      slv_ar_i.id   = slv_id_t'(rand_below(NumSlvIds));
      slv_ar_i.addr = addr_t'($random(seed));
      slv_ar_i.len  = len_t'(rand_below(4));
      ar_valid_i    = 1'b1;
      issued++;
    end
  endtask

  // Memory model answers bursts in order with beat k returning address plus k
  task automatic drive_master_r();
    if (mst_r_valid_i && mst_r_hs) begin
      mst_r_valid_i = 1'b0;
    end
    if (!mst_r_valid_i && rsp_q.size() > 0 && rand_below(3) != 0) begin
      mst_r_i.id        = rsp_q[0].id[MstIdWidth-1:0];
      mst_r_i.beat.data = rsp_q[0].addr + addr_t'(beat_k);
      mst_r_i.beat.resp = '0;
      mst_r_i.beat.last = beat_k == rsp_q[0].len;
      mst_r_valid_i     = 1'b1;
    end
  endtask

  initial begin
    rst_n_i        = 1'b0;
    slv_ar_i       = '0;
    ar_valid_i     = 1'b0;
    r_ready_i      = 1'b0;
    mst_ar_ready_i = 1'b0;
    mst_r_i        = '0;
    mst_r_valid_i  = 1'b0;
    repeat (4) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    while (done_cnt < NumTxns) begin
      @(posedge clk_i);
      #1;
      cycles++;
      if (cycles > TimeoutCycles) begin
        stop_run($sformatf("Timeout with %0d of %0d bursts complete", done_cnt, NumTxns));
      end
      drive_slave_ar();
      drive_master_r();
      mst_ar_ready_i = rand_below(4) != 0;
      r_ready_i      = rand_below(4) != 0;
    end
    $display("Everything OK");
    $finish;
  end

endmodule

// ==== bench/id_serialize_asserts.sv ====
// Concurrent checks on the master AR and slave R handshakes
// and on both valids while reset is active
`timescale 1ns/1ps

module id_serialize_asserts import id_serialize_pkg::*; (
  input logic    clk_i,
  input logic    rst_n_i,
  input mst_ar_t mst_ar_o,
  input logic    mst_ar_valid_o,
  input logic    mst_ar_ready_i,
  input slv_r_t  slv_r_o,
  input logic    r_valid_o,
  input logic    r_ready_i
);

  // Master AR waits for ready with valid and payload held
  mst_ar_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mst_ar_valid_o && !mst_ar_ready_i |=> mst_ar_valid_o && $stable(mst_ar_o))
    else $error("master AR valid or payload changed before ready");

  // Slave R beat waits for ready the same way
  slv_r_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable(slv_r_o))
    else $error("slave R valid or payload changed before ready");

  // Nothing is offered on either port while in reset
  valid_low_in_reset: assert property (@(posedge clk_i)
    !rst_n_i |-> !mst_ar_valid_o && !r_valid_o)
    else $error("valid high during reset");

endmodule

// ==== logic/id_serialize.sv ====
// Top level of the AXI read ID serializer: demux, one serializer per slot, arbiter
`timescale 1ns/1ps

module id_serialize import id_serialize_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_n_i,
  // Slave port
  input  slv_ar_t slv_ar_i,
  input  logic    ar_valid_i,
  output logic    ar_ready_o,
  output slv_r_t  slv_r_o,
  output logic    r_valid_o,
  input  logic    r_ready_i,
  // Master port
  output mst_ar_t mst_ar_o,
  output logic    mst_ar_valid_o,
  input  logic    mst_ar_ready_i,
  input  mst_r_t  mst_r_i,
  input  logic    mst_r_valid_i,
  output logic    mst_r_ready_o
);

  slv_ar_t                dmx_ar;
  logic [NumSlots-1:0]    dmx_ar_valid;
  logic [NumSlots-1:0]    dmx_ar_ready;
  slv_r_t [NumSlots-1:0]  ser_r;
  logic [NumSlots-1:0]    ser_r_valid;
  logic [NumSlots-1:0]    ser_r_ready;
  slv_ar_t [NumSlots-1:0] ser_ar;
  logic [NumSlots-1:0]    ser_ar_valid;
  logic [NumSlots-1:0]    ser_ar_ready;
  r_beat_t                arb_beat;
  logic [NumSlots-1:0]    arb_beat_valid;
  logic [NumSlots-1:0]    arb_beat_ready;

  ar_demux ar_demux_inst (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .slv_ar_i        (slv_ar_i),
    .ar_valid_i      (ar_valid_i),
    .ar_ready_o      (ar_ready_o),
    .slot_ar_o       (dmx_ar),
    .slot_ar_valid_o (dmx_ar_valid),
    .slot_ar_ready_i (dmx_ar_ready),
    .slot_r_i        (ser_r),
    .slot_r_valid_i  (ser_r_valid),
    .slot_r_ready_o  (ser_r_ready),
    .slv_r_o         (slv_r_o),
    .r_valid_o       (r_valid_o),
    .r_ready_i       (r_ready_i)
  );

  for (genvar i = 0; i < NumSlots; i++) begin : gen_slots
    id_serializer id_serializer_inst (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .ar_i         (dmx_ar),
      .ar_valid_i   (dmx_ar_valid[i]),
      .ar_ready_o   (dmx_ar_ready[i]),
      .ar_o         (ser_ar[i]),
      .ar_valid_o   (ser_ar_valid[i]),
      .ar_ready_i   (ser_ar_ready[i]),
      .beat_i       (arb_beat),
      .beat_valid_i (arb_beat_valid[i]),
      .beat_ready_o (arb_beat_ready[i]),
      .r_o          (ser_r[i]),
      .r_valid_o    (ser_r_valid[i]),
      .r_ready_i    (ser_r_ready[i])
    );
  end

  ar_arbiter ar_arbiter_inst (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .slot_ar_i         (ser_ar),
    .slot_ar_valid_i   (ser_ar_valid),
    .slot_ar_ready_o   (ser_ar_ready),
    .mst_ar_o          (mst_ar_o),
    .ar_valid_o        (mst_ar_valid_o),
    .ar_ready_i        (mst_ar_ready_i),
    .mst_r_i           (mst_r_i),
    .r_valid_i         (mst_r_valid_i),
    .r_ready_o         (mst_r_ready_o),
    .slot_beat_o       (arb_beat),
    .slot_beat_valid_o (arb_beat_valid),
    .slot_beat_ready_i (arb_beat_ready)
  );

endmodule

// ==== logic/ar_arbiter.sv ====
// Round-robin AR arbiter over the slots with a one-entry output register
// R beats are routed back to the slot named by the master ID
`timescale 1ns/1ps

module ar_arbiter import id_serialize_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  // AR from the slots
  input  slv_ar_t [NumSlots-1:0] slot_ar_i,
  input  logic [NumSlots-1:0]    slot_ar_valid_i,
  output logic [NumSlots-1:0]    slot_ar_ready_o,
  // Master AR
  output mst_ar_t                mst_ar_o,
  output logic                   ar_valid_o,
  input  logic                   ar_ready_i,
  // Master R
  input  mst_r_t                 mst_r_i,
  input  logic                   r_valid_i,
  output logic                   r_ready_o,
  // R beats to the slots
  output r_beat_t                slot_beat_o,
  output logic [NumSlots-1:0]    slot_beat_valid_o,
  input  logic [NumSlots-1:0]    slot_beat_ready_i
);

  mst_id_t ar_gnt;
  mst_id_t last_q;
  mst_ar_t ar_q;
  logic    full_q;
  logic    load;
  logic    take;

  // Register can take a new AR when empty or emptied in this cycle
  assign load   = !full_q || ar_ready_i;
  assign ar_gnt = rr_pick(slot_ar_valid_i, last_q);
  assign take   = load && (|slot_ar_valid_i);

  assign slot_ar_ready_o = {{(NumSlots-1){1'b0}}, take} << ar_gnt;

  assign mst_ar_o   = ar_q;
  assign ar_valid_o = full_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      full_q <= 1'b0;
      last_q <= '0;
    end else if (take) begin
      full_q <= 1'b1;
      last_q <= ar_gnt;
    end else if (ar_ready_i) begin
      full_q <= 1'b0;
    end
  end

  // Slot index becomes the master ID
  always_ff @(posedge clk_i) begin
    if (take) begin
      ar_q.id   <= ar_gnt;
      ar_q.addr <= slot_ar_i[ar_gnt].addr;
      ar_q.len  <= slot_ar_i[ar_gnt].len;
    end
  end

  // R decode by master ID
  assign slot_beat_o       = mst_r_i.beat;
  assign slot_beat_valid_o = {{(NumSlots-1){1'b0}}, r_valid_i} << mst_r_i.id;
  assign r_ready_o         = slot_beat_ready_i[mst_r_i.id];

endmodule

// ==== logic/id_serializer.sv ====
// One serializer slot: holds back requests with a differing ID while bursts are in flight,
// counts outstanding bursts and restores the slave ID on returning R beats
`timescale 1ns/1ps

module id_serializer import id_serialize_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_n_i,
  // AR from the demux
  input  slv_ar_t ar_i,
  input  logic    ar_valid_i,
  output logic    ar_ready_o,
  // AR towards the arbiter
  output slv_ar_t ar_o,
  output logic    ar_valid_o,
  input  logic    ar_ready_i,
  // R beats from the arbiter
  input  r_beat_t beat_i,
  input  logic    beat_valid_i,
  output logic    beat_ready_o,
  // R with restored ID towards the demux
  output slv_r_t  r_o,
  output logic    r_valid_o,
  input  logic    r_ready_i
);

  slv_id_t id_q;
  cnt_t    cnt_q;
  logic    not_full;
  logic    same_id;
  logic    accept;
  logic    ar_fire;
  logic    r_done;

  // Accept rule
  assign not_full = cnt_q < cnt_t'(MaxTxnsPerId);
  assign same_id  = (cnt_q == '0) || (ar_i.id == id_q);
  assign accept   = not_full && same_id;

  // Request passes only while the rule holds; both valid and ready drop otherwise
  assign ar_o       = ar_i;
  assign ar_valid_o = ar_valid_i && accept;
  assign ar_ready_o = ar_ready_i && accept;
  assign ar_fire    = ar_valid_o && ar_ready_i;

  // All bursts in flight share id_q, so every beat gets it back
  assign r_o.id       = id_q;
  assign r_o.beat     = beat_i;
  assign r_valid_o    = beat_valid_i;
  assign beat_ready_o = r_ready_i;
  assign r_done       = beat_valid_i && r_ready_i && beat_i.last;

  // Outstanding bursts, one per AR sent and one less per last beat
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else begin
      case ({ar_fire, r_done})
        2'b10:   cnt_q <= cnt_q + cnt_t'(1);
        2'b01:   cnt_q <= cnt_q - cnt_t'(1);
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // ID in flight, only meaningful while the count is nonzero
  always_ff @(posedge clk_i) begin
    if (ar_fire) begin
      id_q <= ar_i.id;
    end
  end

endmodule

// ==== logic/ar_demux.sv ====
// AR steering from the slave port to the serializer slots by ID
// Burst-locked round-robin merge of slot R beats back to the slave port
`timescale 1ns/1ps

module ar_demux import id_serialize_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  slv_ar_t                slv_ar_i,
  input  logic                   ar_valid_i,
  output logic                   ar_ready_o,
  output slv_ar_t                slot_ar_o,
  output logic [NumSlots-1:0]    slot_ar_valid_o,
  input  logic [NumSlots-1:0]    slot_ar_ready_i,
  input  slv_r_t [NumSlots-1:0]  slot_r_i,
  input  logic [NumSlots-1:0]    slot_r_valid_i,
  output logic [NumSlots-1:0]    slot_r_ready_o,
  output slv_r_t                 slv_r_o,
  output logic                   r_valid_o,
  input  logic                   r_ready_i
);

  mst_id_t ar_sel;
  mst_id_t r_gnt;
  mst_id_t gnt_q;
  mst_id_t last_q;
  logic    lock_q;

  // Slot index is the slave ID modulo the number of slots
  assign ar_sel          = slv_ar_i.id[MstIdWidth-1:0];
  assign slot_ar_o       = slv_ar_i;
  assign slot_ar_valid_o = {{(NumSlots-1){1'b0}}, ar_valid_i} << ar_sel;
  assign ar_ready_o      = slot_ar_ready_i[ar_sel];

  // While locked the grant stays on the slot whose burst is under way
  assign r_gnt = lock_q ? gnt_q : rr_pick(slot_r_valid_i, last_q);

  assign slv_r_o        = slot_r_i[r_gnt];
  assign r_valid_o      = slot_r_valid_i[r_gnt];
  assign slot_r_ready_o = {{(NumSlots-1){1'b0}}, r_ready_i} << r_gnt;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lock_q <= 1'b0;
      gnt_q  <= '0;
      last_q <= '0;
    end else if (r_valid_o) begin
      if (r_ready_i && slv_r_o.beat.last) begin
        // Burst done, priority moves past this slot
        lock_q <= 1'b0;
        last_q <= r_gnt;
      end else begin
        // Beat pending or burst continues
        lock_q <= 1'b1;
        gnt_q  <= r_gnt;
      end
    end
  end

endmodule

// ==== logic/id_serialize_pkg.sv ====
// Sizes, ID/address/data types and AR/R channel structs for the read ID serializer
// Round-robin pick function shared by the demux and the arbiter
package id_serialize_pkg;

  localparam int unsigned SlvIdWidth   = 4;
  localparam int unsigned MstIdWidth   = 2;
  localparam int unsigned NumSlots     = 2 ** MstIdWidth;
  localparam int unsigned MaxTxnsPerId = 4;
  localparam int unsigned AddrWidth    = 32;
  localparam int unsigned DataWidth    = 32;
  localparam int unsigned LenWidth     = 8;
  localparam int unsigned RespWidth    = 2;
  // Count must reach MaxTxnsPerId itself
  localparam int unsigned CntWidth     = $clog2(MaxTxnsPerId + 1);

  typedef logic [SlvIdWidth-1:0] slv_id_t;
  typedef logic [MstIdWidth-1:0] mst_id_t;
  typedef logic [AddrWidth-1:0]  addr_t;
  typedef logic [DataWidth-1:0]  data_t;
  typedef logic [LenWidth-1:0]   len_t;
  typedef logic [RespWidth-1:0]  resp_t;
  typedef logic [CntWidth-1:0]   cnt_t;

  typedef struct packed {
    slv_id_t id;
    addr_t   addr;
    len_t    len;
  } slv_ar_t;

  typedef struct packed {
    mst_id_t id;
    addr_t   addr;
    len_t    len;
  } mst_ar_t;

  typedef struct packed {
    data_t data;
    resp_t resp;
    logic  last;
  } r_beat_t;

  typedef struct packed {
    slv_id_t id;
    r_beat_t beat;
  } slv_r_t;

  typedef struct packed {
    mst_id_t id;
    r_beat_t beat;
  } mst_r_t;

  // First requesting slot after last, wrapping around; returns last if none requests
  function automatic mst_id_t rr_pick(input logic [NumSlots-1:0] req, input mst_id_t last);
    mst_id_t idx;
    mst_id_t pick;
    logic    found;
    pick  = last;
    found = 1'b0;
    for (int unsigned i = 1; i <= NumSlots; i++) begin
      idx = last + mst_id_t'(i);
      if (!found && req[idx]) begin
        pick  = idx;
        found = 1'b1;
      end
    end
    return pick;
  endfunction

endpackage
